/* common/connect_four_macros.svh */
`ifndef CONNECT_FOUR_MACROS_SVH
`define CONNECT_FOUR_MACROS_SVH

// Board geometry, row 0 is the bottom
`define CF_ROWS 8
`define CF_COLS 8

// Index widths for rows and columns
`define CF_ROW_BITS 3
`define CF_COL_BITS 3

// Pieces in a line needed to win
`define CF_WIN_LEN 4

// Flops per button synchronizer
`define CF_SYNC_STAGES 3

`endif

/* common/connect_four_pkg.sv */
`default_nettype none

`include "connect_four_macros.svh"

package connect_four_pkg;

    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_P1    = 2'b01,
        CELL_P2    = 2'b10
    } cell_t;

    typedef logic [`CF_ROW_BITS-1:0] row_t;
    typedef logic [`CF_COL_BITS-1:0] col_t;

    // One extra bit so a full column reads as CF_ROWS
    typedef logic [`CF_ROW_BITS:0] height_t;

    // Indexed as [row][col]
    typedef cell_t [`CF_ROWS-1:0][`CF_COLS-1:0] board_t;

    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLACE,
        GAME_CHECK,
        GAME_WON
    } game_state_t;

    typedef enum logic [3:0] {
        STEP_VERT,
        STEP_ROW_0, STEP_ROW_1, STEP_ROW_2, STEP_ROW_3,
        STEP_RISE_0, STEP_RISE_1, STEP_RISE_2, STEP_RISE_3,
        STEP_FALL_0, STEP_FALL_1, STEP_FALL_2, STEP_FALL_3
    } check_step_t;

endpackage

`default_nettype wire

/* design/board_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "connect_four_macros.svh"

module board_store
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   place_go,
    input  connect_four_pkg::col_t  cursor_col,
    input  connect_four_pkg::cell_t current_player,
    output connect_four_pkg::board_t board,
    output connect_four_pkg::row_t  place_row,
    output logic                   col_full
);

    import connect_four_pkg::*;

    height_t heights [`CF_COLS];
    height_t sel_height;

    // Fill height of the cursor column is the next free row
    assign sel_height = heights[cursor_col];
    assign place_row  = sel_height[`CF_ROW_BITS-1:0];
    assign col_full   = (sel_height == height_t'(`CF_ROWS));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            board <= '0;
            for (int c = 0; c < `CF_COLS; c++)
            begin
                heights[c] <= '0;
            end
        end
        else if (place_go && !col_full)
        begin
            board[place_row][cursor_col] <= current_player;
            heights[cursor_col]          <= sel_height + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/button_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "connect_four_macros.svh"

module button_sync
(
    input  logic clk,
    input  logic rst_n,
    input  logic btn_left,
    input  logic btn_right,
    input  logic btn_drop,
    output logic press_left,
    output logic press_right,
    output logic press_drop
);

    // Bit 0 left, bit 1 right, bit 2 drop
    logic [2:0]                      btn_raw;
    logic [2:0][`CF_SYNC_STAGES-1:0] sync;
    logic [2:0]                      press_q;

    assign btn_raw = {btn_drop, btn_right, btn_left};

    // Buttons are active low, so all ones is the released state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync    <= '1;
            press_q <= '0;
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                sync[i] <= {sync[i][`CF_SYNC_STAGES-2:0], btn_raw[i]};
                // Released in the oldest stage, pressed in the one before
                press_q[i] <= sync[i][`CF_SYNC_STAGES-1] & ~sync[i][`CF_SYNC_STAGES-2];
            end
        end
    end

    assign press_left  = press_q[0];
    assign press_right = press_q[1];
    assign press_drop  = press_q[2];

endmodule

`default_nettype wire

/* design/connect_four.sv */
`timescale 1ns/1ps
`default_nettype none

module connect_four
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   btn_left,
    input  logic                   btn_right,
    input  logic                   btn_drop,
    output connect_four_pkg::board_t board,
    output connect_four_pkg::col_t  cursor_col,
    output connect_four_pkg::cell_t current_player,
    output logic                   game_over,
    output connect_four_pkg::cell_t winner
);

    import connect_four_pkg::*;

    logic press_left;
    logic press_right;
    logic press_drop;
    logic place_go;
    logic col_full;
    row_t place_row;
    logic check_start;
    logic check_done;
    logic win;
    row_t check_row;
    col_t check_col;

    button_sync button_sync_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_drop    (btn_drop),
        .press_left  (press_left),
        .press_right (press_right),
        .press_drop  (press_drop)
    );

    game_ctrl game_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .press_left     (press_left),
        .press_right    (press_right),
        .press_drop     (press_drop),
        .col_full       (col_full),
        .check_done     (check_done),
        .win            (win),
        .place_row      (place_row),
        .place_go       (place_go),
        .check_start    (check_start),
        .cursor_col     (cursor_col),
        .check_col      (check_col),
        .check_row      (check_row),
        .current_player (current_player),
        .game_over      (game_over),
        .winner         (winner)
    );

    board_store board_store_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .place_go       (place_go),
        .cursor_col     (cursor_col),
        .current_player (current_player),
        .board          (board),
        .place_row      (place_row),
        .col_full       (col_full)
    );

    // The player does not change until the check completes
    win_checker win_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .check_start  (check_start),
        .board        (board),
        .check_row    (check_row),
        .check_col    (check_col),
        .check_player (current_player),
        .check_done   (check_done),
        .win          (win)
    );

endmodule

`default_nettype wire

/* game_ctrl/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "connect_four_macros.svh"

module game_ctrl
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   press_left,
    input  logic                   press_right,
    input  logic                   press_drop,
    input  logic                   col_full,
    input  logic                   check_done,
    input  logic                   win,
    input  connect_four_pkg::row_t  place_row,
    output logic                   place_go,
    output logic                   check_start,
    output connect_four_pkg::col_t  cursor_col,
    output connect_four_pkg::col_t  check_col,
    output connect_four_pkg::row_t  check_row,
    output connect_four_pkg::cell_t current_player,
    output logic                   game_over,
    output connect_four_pkg::cell_t winner
);

    import connect_four_pkg::*;

    game_state_t state;
    logic        move_right;
    logic        move_left;
    col_t        col_right;
    col_t        col_left;

    // Both directions at once cancel out
    assign move_right = press_right & ~press_left;
    assign move_left  = press_left & ~press_right;

    assign col_right = (cursor_col == col_t'(`CF_COLS - 1)) ? '0 : cursor_col + 1'b1;
    assign col_left  = (cursor_col == '0) ? col_t'(`CF_COLS - 1) : cursor_col - 1'b1;

    assign place_go  = (state == GAME_PLACE);
    assign game_over = (state == GAME_WON);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= GAME_IDLE;
            cursor_col     <= '0;
            current_player <= CELL_P1;
            winner         <= CELL_EMPTY;
            check_start    <= 1'b0;
        end
        else
        begin
            check_start <= 1'b0;
            case (state)
                GAME_IDLE:
                begin
                    if (press_drop)
                    begin
                        state <= GAME_PLACE;
                    end
                    else if (move_right)
                    begin
                        cursor_col <= col_right;
                    end
                    else if (move_left)
                    begin
                        cursor_col <= col_left;
                    end
                end
                GAME_PLACE:
                begin
                    // A full column refuses the piece and the turn stays
                    if (col_full)
                    begin
                        state <= GAME_IDLE;
                    end
                    else
                    begin
                        state       <= GAME_CHECK;
                        check_start <= 1'b1;
                    end
                end
                GAME_CHECK:
                begin
                    if (check_done && win)
                    begin
                        state  <= GAME_WON;
                        winner <= current_player;
                    end
                    else if (check_done)
                    begin
                        state          <= GAME_IDLE;
                        current_player <= (current_player == CELL_P1) ? CELL_P2 : CELL_P1;
                    end
                end
                default:
                begin
                    state <= GAME_WON;
                end
            endcase
        end
    end

    // Placed position, held for the whole check
    always_ff @(posedge clk)
    begin
        if (state == GAME_PLACE && !col_full)
        begin
            check_row <= place_row;
            check_col <= cursor_col;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f src.f --top-module connect_four_tb \
    -Mdir "$BUILD_DIR" -o connect_four_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/connect_four_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0

/* sim/connect_four_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "connect_four_macros.svh"

module connect_four_tb;

    import connect_four_pkg::*;

    // Upper bound on button presses over all tests
    localparam int MAX_PRESSES = 700;

    logic   clk;
    logic   rst_n;
    logic   btn_left;
    logic   btn_right;
    logic   btn_drop;
    board_t board;
    col_t   cursor_col;
    cell_t  current_player;
    logic   game_over;
    cell_t  winner;

    // Reference model of the game
    board_t model_board;
    int     model_height [`CF_COLS];
    int     model_cursor;
    cell_t  model_player;
    logic   model_over;
    cell_t  model_winner;
    logic   check_en;
    int     seq [$];

    connect_four connect_four_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .btn_left       (btn_left),
        .btn_right      (btn_right),
        .btn_drop       (btn_drop),
        .board          (board),
        .cursor_col     (cursor_col),
        .current_player (current_player),
        .game_over      (game_over),
        .winner         (winner)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("Something failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    board_matches: assert property (@(posedge clk) disable iff (!rst_n)
        check_en |-> board == model_board)
        else report_mismatch("board differs from the reference model");
    cursor_matches: assert property (@(posedge clk) disable iff (!rst_n)
        check_en |-> cursor_col == col_t'(model_cursor))
        else report_mismatch("cursor_col differs from the reference model");
    player_matches: assert property (@(posedge clk) disable iff (!rst_n)
        check_en |-> current_player == model_player)
        else report_mismatch("current_player differs from the reference model");
    over_matches: assert property (@(posedge clk) disable iff (!rst_n)
        check_en |-> game_over == model_over)
        else report_mismatch("game_over differs from the reference model");
    winner_matches: assert property (@(posedge clk) disable iff (!rst_n)
        check_en |-> winner == model_winner)
        else report_mismatch("winner differs from the reference model");

    // Equal cells next to (r, c) going one way, the cell itself not counted
    function automatic int run_length(int r, int c, int dr, int dc, cell_t p);
        int n;
        int rr;
        int cc;
        n  = 0;
        rr = r + dr;
        cc = c + dc;
        while (rr >= 0 && rr < `CF_ROWS && cc >= 0 && cc < `CF_COLS
               && model_board[row_t'(rr)][col_t'(cc)] == p)
        begin
            n++;
            rr += dr;
            cc += dc;
        end
        return n;
    endfunction

    function automatic int line_length(int r, int c, int dr, int dc, cell_t p);
        return 1 + run_length(r, c, dr, dc, p) + run_length(r, c, -dr, -dc, p);
    endfunction

    function automatic logic makes_four(int r, int c, cell_t p);
        return line_length(r, c, 1, 0, p) >= `CF_WIN_LEN
            || line_length(r, c, 0, 1, p) >= `CF_WIN_LEN
            || line_length(r, c, 1, 1, p) >= `CF_WIN_LEN
            || line_length(r, c, 1, -1, p) >= `CF_WIN_LEN;
    endfunction

    task automatic model_drop();
        int r;
        r = model_height[model_cursor];
        if (r < `CF_ROWS)
        begin
            model_board[row_t'(r)][col_t'(model_cursor)] = model_player;
            model_height[model_cursor] = r + 1;
            if (makes_four(r, model_cursor, model_player))
            begin
                model_over   = 1'b1;
                model_winner = model_player;
            end
            else
            begin
                model_player = (model_player == CELL_P1) ? CELL_P2 : CELL_P1;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        model_board  = '0;
        model_cursor = 0;
        model_player = CELL_P1;
        model_over   = 1'b0;
        model_winner = CELL_EMPTY;
        foreach (model_height[c])
        begin
            model_height[c] = 0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Compare against the model at the next rising edge
    task automatic pulse_check();
        @(negedge clk);
        check_en = 1'b1;
        @(negedge clk);
        check_en = 1'b0;
    endtask

    task automatic press_buttons(input logic left, input logic right, input logic drop);
        pulse_check();
        btn_left  = ~left;
        btn_right = ~right;
        btn_drop  = ~drop;
        repeat (6) @(negedge clk);
        btn_left  = 1'b1;
        btn_right = 1'b1;
        btn_drop  = 1'b1;
        repeat (24) @(negedge clk);
        if (!model_over)
        begin
            if (drop)
                model_drop();
            else if (right && !left)
                model_cursor = (model_cursor + 1) % `CF_COLS;
            else if (left && !right)
                model_cursor = (model_cursor + `CF_COLS - 1) % `CF_COLS;
        end
    endtask

    // Shortest way round to the column, then drop
    task automatic drop_in(input int col);
        while (model_cursor != col)
        begin
            if ((col - model_cursor + `CF_COLS) % `CF_COLS <= `CF_COLS / 2)
                press_buttons(1'b0, 1'b1, 1'b0);
            else
                press_buttons(1'b1, 1'b0, 1'b0);
        end
        press_buttons(1'b0, 1'b0, 1'b1);
    endtask

    task automatic play_random_game();
        int drops;
        int moves;
        drops = 0;
        while (!model_over && drops < 40)
        begin
            moves = $urandom % 3;
            repeat (moves)
            begin
                if ($urandom % 2)
                    press_buttons(1'b0, 1'b1, 1'b0);
                else
                    press_buttons(1'b1, 1'b0, 1'b0);
            end
            drop_in($urandom % `CF_COLS);
            drops++;
        end
    endtask

    initial
    begin
        repeat (MAX_PRESSES * 40 + 2000) @(posedge clk);
        $display("Timeout: the tests did not finish within the watchdog limit");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        void'($urandom(32'hbc0b));
        clk       = 1'b0;
        rst_n     = 1'b0;
        btn_left  = 1'b1;
        btn_right = 1'b1;
        btn_drop  = 1'b1;
        check_en  = 1'b0;
        apply_reset();
        pulse_check();

        // Cursor wraps both ways, both buttons together do nothing
        repeat (8) press_buttons(1'b0, 1'b1, 1'b0);
        press_buttons(1'b1, 1'b0, 1'b0);
        press_buttons(1'b1, 1'b1, 1'b0);

        // Nine drops into column 0, the last one refused
        drop_in(0);
        repeat (8) press_buttons(1'b0, 1'b0, 1'b1);
        pulse_check();

        // Vertical win for player 1, then buttons are ignored
        apply_reset();
        seq = '{0, 1, 0, 1, 0, 1, 0};
        foreach (seq[i]) drop_in(seq[i]);
        press_buttons(1'b0, 1'b1, 1'b0);
        press_buttons(1'b1, 1'b0, 1'b0);
        press_buttons(1'b0, 1'b0, 1'b1);
        pulse_check();

        // Horizontal win closed in the middle, three stacked for player 2
        apply_reset();
        seq = '{1, 7, 2, 7, 4, 7, 3};
        foreach (seq[i]) drop_in(seq[i]);
        pulse_check();

        apply_reset();
        seq = '{0, 1, 1, 2, 3, 2, 2, 3, 6, 3, 3};
        foreach (seq[i]) drop_in(seq[i]);
        pulse_check();

        repeat (2)
        begin
            apply_reset();
            play_random_game();
            pulse_check();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/connect_four_pkg.sv
design/button_sync.sv
design/board_store.sv
game_ctrl/game_ctrl.sv
win_check/win_checker.sv
design/connect_four.sv
sim/connect_four_tb.sv

/* win_check/win_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "connect_four_macros.svh"

module win_checker
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   check_start,
    input  connect_four_pkg::board_t board,
    input  connect_four_pkg::row_t  check_row,
    input  connect_four_pkg::col_t  check_col,
    input  connect_four_pkg::cell_t check_player,
    output logic                   check_done,
    output logic                   win
);

    import connect_four_pkg::*;

    check_step_t step;
    logic        busy;
    logic        hit;
    logic        window_hit;

    // Line direction and the placed piece's position within the window
    int          dir_row;
    int          dir_col;
    int          ofs;
    int          cell_row;
    int          cell_col;

    always_comb
    begin
        if (step == STEP_VERT)
        begin
            // Nothing sits above the last piece, so it tops the column
            dir_row = 1;
            dir_col = 0;
            ofs     = `CF_WIN_LEN - 1;
        end
        else if (step <= STEP_ROW_3)
        begin
            dir_row = 0;
            dir_col = 1;
            ofs     = int'(step) - int'(STEP_ROW_0);
        end
        else if (step <= STEP_RISE_3)
        begin
            dir_row = 1;
            dir_col = 1;
            ofs     = int'(step) - int'(STEP_RISE_0);
        end
        else
        begin
            dir_row = -1;
            dir_col = 1;
            ofs     = int'(step) - int'(STEP_FALL_0);
        end

        window_hit = 1'b1;
        cell_row   = 0;
        cell_col   = 0;
        for (int i = 0; i < `CF_WIN_LEN; i++)
        begin
            cell_row = int'(check_row) + (i - ofs) * dir_row;
            cell_col = int'(check_col) + (i - ofs) * dir_col;
            if (cell_row < 0 || cell_row >= `CF_ROWS || cell_col < 0 || cell_col >= `CF_COLS)
            begin
                window_hit = 1'b0;
            end
            else if (board[row_t'(cell_row)][col_t'(cell_col)] != check_player)
            begin
                window_hit = 1'b0;
            end
        end
    end

    // Last window is judged in the done cycle itself
    assign check_done = busy && (step == STEP_FALL_3);
    assign win        = hit | window_hit;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            step <= STEP_VERT;
            hit  <= 1'b0;
        end
        else if (check_start)
        begin
            busy <= 1'b1;
            step <= STEP_VERT;
            hit  <= 1'b0;
        end
        else if (busy)
        begin
            hit <= hit | window_hit;
            if (step == STEP_FALL_3)
            begin
                busy <= 1'b0;
            end
            else
            begin
                step <= check_step_t'(step + 1'b1);
            end
        end
    end

endmodule

`default_nettype wire
